// File: exuAlu.sv
`timescale 1ns/1ps

module exuAlu import exuTypesPkg::*, exuIsaPkg::*;
(
    exuCtrlIf.execute ctrl,
    input  word_t     srcA,
    input  word_t     rtValue,
    input  shamt_t    shamt,
    output word_t     result
);

    word_t  srcB;
    shamt_t shiftAmt;

    assign srcB     = ctrl.useImm ? ctrl.immExt : rtValue;
    assign shiftAmt = ctrl.shiftVar ? srcA[4:0] : shamt;   // variable shifts use rs

    always_comb
    begin
        case (ctrl.aluOp)
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluNor:  result = ~(srcA | srcB);
            aluAdd:  result = srcA + srcB;   // wraps
            aluSub:  result = srcA - srcB;
            aluSlt:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            aluSltu: result = {31'd0, srcA < srcB};
            aluSll:  result = srcB << shiftAmt;
            aluSrl:  result = srcB >> shiftAmt;
            aluSra:  result = word_t'($signed(srcB) >>> shiftAmt);
            aluLui:  result = {srcB[15:0], 16'd0};
            default: result = '0;
        endcase
    end

endmodule

// File: exuCtrlIf.sv
`timescale 1ns/1ps

interface exuCtrlIf import exuTypesPkg::*, exuIsaPkg::*;
();

    aluOp_t    aluOp;
    logic      useImm;    // operand B from immediate
    word_t     immExt;
    logic      shiftVar;  // shift amount from rs
    regNum_t   writeReg;
    logic      writeEn;
    hiLoSel_t  hiLoSel;
    mulDivOp_t mulDivOp;

    modport decode (
        output aluOp, useImm, immExt, shiftVar,
        output writeReg, writeEn, hiLoSel, mulDivOp
    );

    modport execute (input aluOp, useImm, immExt, shiftVar);

    modport result (input writeReg, writeEn, hiLoSel, mulDivOp);

endinterface

// File: exuDecode.sv
`timescale 1ns/1ps

module exuDecode import exuTypesPkg::*, exuIsaPkg::*;
(
    input instr_t    instr,
    exuCtrlIf.decode ctrl
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regNum_t     rtNum;
    regNum_t     rdNum;
    logic [15:0] imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rtNum  = instr[20:16];
    assign rdNum  = instr[15:11];
    assign imm    = instr[15:0];

    always_comb
    begin
        // defaults: i-type shape, no write; loads/stores just form rs + imm
        ctrl.aluOp    = aluAdd;
        ctrl.useImm   = 1'b1;
        ctrl.immExt   = {{16{imm[15]}}, imm};
        ctrl.shiftVar = 1'b0;
        ctrl.writeReg = rtNum;
        ctrl.writeEn  = 1'b0;
        ctrl.hiLoSel  = selAlu;
        ctrl.mulDivOp = mdNone;

        case (opcode)
            opSpecial:
            begin
                ctrl.useImm   = 1'b0;
                ctrl.writeReg = rdNum;
                ctrl.writeEn  = 1'b1;
                case (funct)
                    fnSll:
                    begin
                        ctrl.aluOp   = aluSll;
                        ctrl.writeEn = (instr != '0);   // nop
                    end
                    fnSrl:          ctrl.aluOp = aluSrl;
                    fnSra:          ctrl.aluOp = aluSra;
                    fnSllv:
                    begin
                        ctrl.aluOp    = aluSll;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnSrlv:
                    begin
                        ctrl.aluOp    = aluSrl;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnSrav:
                    begin
                        ctrl.aluOp    = aluSra;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnMfhi:         ctrl.hiLoSel = selHi;
                    fnMflo:         ctrl.hiLoSel = selLo;
                    fnMthi:
                    begin
                        ctrl.mulDivOp = mdMthi;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnMtlo:
                    begin
                        ctrl.mulDivOp = mdMtlo;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnMult:
                    begin
                        ctrl.mulDivOp = mdMult;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnMultu:
                    begin
                        ctrl.mulDivOp = mdMultu;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnDiv:
                    begin
                        ctrl.mulDivOp = mdDiv;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnDivu:
                    begin
                        ctrl.mulDivOp = mdDivu;
                        ctrl.writeEn  = 1'b0;
                    end
                    fnAdd, fnAddu:  ctrl.aluOp = aluAdd;   // no overflow trap
                    fnSub, fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:          ctrl.aluOp = aluAnd;
                    fnOr:           ctrl.aluOp = aluOr;
                    fnXor:          ctrl.aluOp = aluXor;
                    fnNor:          ctrl.aluOp = aluNor;
                    fnSlt:          ctrl.aluOp = aluSlt;
                    fnSltu:         ctrl.aluOp = aluSltu;
                    default:        ctrl.writeEn = 1'b0;
                endcase
            end
            opAddi, opAddiu:
            begin
                ctrl.aluOp   = aluAdd;
                ctrl.writeEn = 1'b1;
            end
            opSlti:
            begin
                ctrl.aluOp   = aluSlt;
                ctrl.writeEn = 1'b1;
            end
            opSltiu:
            begin
                ctrl.aluOp   = aluSltu;   // sign-extended imm, unsigned compare
                ctrl.writeEn = 1'b1;
            end
            opAndi, opOri, opXori:
            begin
                ctrl.immExt  = {16'd0, imm};   // logic ops zero-extend
                ctrl.aluOp   = (opcode == opAndi) ? aluAnd :
                               (opcode == opOri)  ? aluOr  : aluXor;
                ctrl.writeEn = 1'b1;
            end
            opLui:
            begin
                ctrl.aluOp   = aluLui;
                ctrl.writeEn = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: exuIsaPkg.sv
package exuIsaPkg;

    //////////////////////////////////////////////////////////////////////
    // opcode field, instr[31:26]
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;

    //////////////////////////////////////////////////////////////////////
    // funct field for special, instr[5:0]
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnSrl   = 6'b000010;
    localparam logic [5:0] fnSra   = 6'b000011;
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrlv  = 6'b000110;
    localparam logic [5:0] fnSrav  = 6'b000111;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnDiv   = 6'b011010;
    localparam logic [5:0] fnDivu  = 6'b011011;
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnSubu  = 6'b100011;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    //////////////////////////////////////////////////////////////////////
    // execute control encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        aluAnd, aluOr, aluXor, aluNor, aluAdd, aluSub,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    typedef enum logic [2:0] {
        mdNone, mdMult, mdMultu, mdDiv, mdDivu, mdMthi, mdMtlo
    } mulDivOp_t;

    typedef enum logic [1:0] {selAlu, selHi, selLo} hiLoSel_t;

    typedef enum logic {mdIdle, mdRun} mulDivState_t;

    localparam int mulDivSteps = 32;                      // one bit per step
    localparam int mulDivCntW  = $clog2(mulDivSteps + 1); // counts the sign-fix slot too

endpackage

// File: exuMulDiv.sv
`timescale 1ns/1ps

module exuMulDiv import exuTypesPkg::*, exuIsaPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      start,
    input  mulDivOp_t op,
    input  word_t     srcA,
    input  word_t     srcB,
    output logic      busy,
    output word_t     hi,
    output word_t     lo
);

    mulDivState_t          state;
    logic [mulDivCntW-1:0] stepCnt;
    mulDivOp_t             curOp;
    word_t                 operand;   // multiplicand or divisor magnitude
    logic                  negA;
    logic                  negB;
    logic                  isSigned;
    logic                  lastStep;
    word_t                 magA;
    word_t                 magB;
    logic [32:0]           mulSum;
    logic [32:0]           divShift;
    logic [32:0]           divDiff;
    logic [63:0]           negProd;

    assign isSigned = (op == mdMult) || (op == mdDiv);
    assign magA     = (isSigned && srcA[31]) ? -srcA : srcA;
    assign magB     = (isSigned && srcB[31]) ? -srcB : srcB;
    assign busy     = (state == mdRun);
    assign lastStep = (stepCnt == mulDivCntW'(mulDivSteps));

    // hi is the running partial product / partial remainder
    assign mulSum   = {1'b0, hi} + (lo[0] ? {1'b0, operand} : 33'd0);
    assign divShift = {hi, lo[31]};
    assign divDiff  = divShift - {1'b0, operand};   // bit 32 set when it does not fit
    assign negProd  = -{hi, lo};

    //////////////////////////////////////////////////////////////////////
    // operand capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (start && (state == mdIdle))
        begin
            curOp   <= op;
            operand <= magB;
            negA    <= isSigned && srcA[31];
            negB    <= isSigned && srcB[31];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // step FSM, HI and LO
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= mdIdle;
            stepCnt <= '0;
            hi      <= '0;
            lo      <= '0;
        end
        else
        begin
            case (state)
                mdIdle:
                begin
                    if (start)
                    begin
                        case (op)
                            mdMthi: hi <= srcA;
                            mdMtlo: lo <= srcA;
                            mdMult, mdMultu, mdDiv, mdDivu:
                            begin
                                hi      <= '0;
                                lo      <= magA;   // multiplier or dividend
                                stepCnt <= '0;
                                state   <= mdRun;
                            end
                            default: ;
                        endcase
                    end
                end
                mdRun:
                begin
                    stepCnt <= stepCnt + 1'b1;
                    if (lastStep)
                    begin
                        state <= mdIdle;   // sign-fix slot
                        if ((curOp == mdMult) && (negA ^ negB))
                            {hi, lo} <= negProd;
                        if (curOp == mdDiv)
                        begin
                            if (negA)
                                hi <= -hi;   // remainder follows dividend
                            if ((negA ^ negB) && (operand != '0))
                                lo <= -lo;
                        end
                    end
                    else if ((curOp == mdMult) || (curOp == mdMultu))
                    begin
                        {hi, lo} <= {mulSum, lo[31:1]};
                    end
                    else if (!divDiff[32])
                    begin
                        hi <= divDiff[31:0];
                        lo <= {lo[30:0], 1'b1};
                    end
                    else
                    begin
                        hi <= divShift[31:0];   // restore
                        lo <= {lo[30:0], 1'b0};
                    end
                end
                default: state <= mdIdle;
            endcase
        end
    end

endmodule

// File: exuResult.sv
`timescale 1ns/1ps

module exuResult import exuTypesPkg::*, exuIsaPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    exuCtrlIf.result ctrl,
    input  logic     cyc,
    input  logic     stb,
    input  logic     busy,
    input  word_t    aluResult,
    input  word_t    hi,
    input  word_t    lo,
    output logic     start,
    output logic     ack,
    output word_t    result,
    output regNum_t  writeReg,
    output logic     writeEn
);

    logic  needsMd;
    logic  accept;
    word_t selValue;

    // hi/lo readers and mul/div ops wait for the running op
    assign needsMd = (ctrl.hiLoSel != selAlu) || (ctrl.mulDivOp != mdNone);
    assign accept  = cyc && stb && !ack && !(busy && needsMd);
    assign start   = accept && (ctrl.mulDivOp != mdNone);   // same edge that raises ack

    always_comb
    begin
        case (ctrl.hiLoSel)
            selHi:   selValue = hi;
            selLo:   selValue = lo;
            default: selValue = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            ack     <= 1'b0;
            writeEn <= 1'b0;
        end
        else
        begin
            ack     <= accept;   // single-cycle ack
            writeEn <= accept && ctrl.writeEn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            result   <= selValue;
            writeReg <= ctrl.writeReg;
        end
    end

endmodule

// File: exuStim.txt
# instr    rs rt rsData   rtData   we wr result   (all fields hex)
# we, wr and result are the expected write port; wr and result only checked when we is 1
00221820 01 02 00001234 00000111 1 03 00001345
00221822 01 02 00000005 00000007 1 03 fffffffe
00221824 01 02 f0f0f0f0 ff00ff00 1 03 f000f000
00221825 01 02 12340000 00005678 1 03 12345678
00221826 01 02 aaaaaaaa ffff0000 1 03 5555aaaa
00221827 01 02 0f0f0000 000000f0 1 03 f0f0ff0f
0022182a 01 02 ffffffff 00000001 1 03 00000001
0022182b 01 02 ffffffff 00000001 1 03 00000000
2022ffff 01 02 00000010 deadbeef 1 02 0000000f
3022ffff 01 02 12345678 deadbeef 1 02 00005678
34228000 01 02 00000001 00000000 1 02 00008001
3822ff00 01 02 0000f0f0 00000000 1 02 00000ff0
2822fffe 01 02 fffffffd 00000000 1 02 00000001
2c22ffff 01 02 00000005 00000000 1 02 00000001
3c02beef 00 02 11111111 00000000 1 02 beef0000
00021900 00 02 ffffffff 0000000f 1 03 000000f0
00021a02 00 02 00000000 80000000 1 03 00800000
00021903 00 02 00000000 80000000 1 03 f8000000
00221804 01 02 00000023 00000001 1 03 00000008
00221806 01 02 0000001f ffffffff 1 03 00000001
00221807 01 02 00000010 ff000000 1 03 ffffff00
00021820 00 02 55555555 00000007 1 03 00000007
00202825 01 00 00000100 ffffffff 1 05 00000100
00000000 00 00 12345678 9abcdef0 0 00 00000000
fc220000 01 02 00000001 00000002 0 00 00000000
00221801 01 02 00000001 00000002 0 00 00000000
00220018 01 02 fffffffd 00000007 0 00 00000000
00221821 01 02 00000064 00000001 1 03 00000065
00001810 00 00 00000000 00000000 1 03 ffffffff
00001812 00 00 00000000 00000000 1 03 ffffffeb
00220019 01 02 ffffffff ffffffff 0 00 00000000
00001810 00 00 00000000 00000000 1 03 fffffffe
00001812 00 00 00000000 00000000 1 03 00000001
0022001a 01 02 fffffff9 00000002 0 00 00000000
00001812 00 00 00000000 00000000 1 03 fffffffd
00001810 00 00 00000000 00000000 1 03 ffffffff
0022001b 01 02 fffffff9 00000010 0 00 00000000
00001812 00 00 00000000 00000000 1 03 0fffffff
00001810 00 00 00000000 00000000 1 03 00000009
0022001a 01 02 ffffff00 00000000 0 00 00000000
00001810 00 00 00000000 00000000 1 03 ffffff00
00001812 00 00 00000000 00000000 1 03 ffffffff
00200011 01 00 cafef00d 00000000 0 00 00000000
00200013 01 00 0badc0de 00000000 0 00 00000000
00001810 00 00 00000000 00000000 1 03 cafef00d
00001812 00 00 00000000 00000000 1 03 0badc0de

// File: exuTb.sv
`timescale 1ns/1ps

module exuTb import exuTypesPkg::*, exuIsaPkg::*;
();

    logic    clk;
    logic    arstN;
    logic    cyc;
    logic    stb;
    instr_t  instr;
    regNum_t rsNum;
    regNum_t rtNum;
    word_t   rsData;
    word_t   rtData;
    logic    ack;
    word_t   result;
    regNum_t writeReg;
    logic    writeEn;
    word_t   storeData;

    // one entry per stimulus line
    instr_t  vInstr[$];
    regNum_t vRsNum[$];
    regNum_t vRtNum[$];
    word_t   vRsData[$];
    word_t   vRtData[$];
    logic    vWriteEn[$];
    regNum_t vWriteReg[$];
    word_t   vResult[$];

    int          numVecs   = 0;
    int unsigned lcgState  = 56498;

    exuTop dut (
        .clk       (clk),
        .arstN     (arstN),
        .cyc       (cyc),
        .stb       (stb),
        .instr     (instr),
        .rsNum     (rsNum),
        .rtNum     (rtNum),
        .rsData    (rsData),
        .rtData    (rtData),
        .ack       (ack),
        .result    (result),
        .writeReg  (writeReg),
        .writeEn   (writeEn),
        .storeData (storeData)
    );

    always #20 clk = ~clk;   // 40 ns period

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string field);
        if (got !== exp)
            stopRun($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                              $time, field, got, exp));
    endtask

    task automatic checkReg(input regNum_t got, input regNum_t exp, input string field);
        if (got !== exp)
            stopRun($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                              $time, field, got, exp));
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string field);
        if (got !== exp)
            stopRun($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                              $time, field, got, exp));
    endtask

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // hi/lo readers and mul/div ops may be held back by a running op
    function automatic logic waitsOnMulDiv(input instr_t i);
        return (i[31:26] == opSpecial) &&
               (i[5:0] inside {fnMfhi, fnMthi, fnMflo, fnMtlo,
                               fnMult, fnMultu, fnDiv, fnDivu});
    endfunction

    task automatic loadStim();
        int      fd;
        int      cnt;
        string   line;
        instr_t  fInstr;
        regNum_t fRsNum;
        regNum_t fRtNum;
        word_t   fRsData;
        word_t   fRtData;
        logic    fWriteEn;
        regNum_t fWriteReg;
        word_t   fResult;
        fd = $fopen("exuStim.txt", "r");
        if (fd == 0)
            stopRun("could not open exuStim.txt");
        while ($fgets(line, fd) > 0)
        begin
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", fInstr, fRsNum, fRtNum,
                          fRsData, fRtData, fWriteEn, fWriteReg, fResult);
            if (cnt == 8)
            begin
                vInstr.push_back(fInstr);
                vRsNum.push_back(fRsNum);
                vRtNum.push_back(fRtNum);
                vRsData.push_back(fRsData);
                vRtData.push_back(fRtData);
                vWriteEn.push_back(fWriteEn);
                vWriteReg.push_back(fWriteReg);
                vResult.push_back(fResult);
            end
            else if ((line.len() > 1) && (line.substr(0, 0) != "#"))
                stopRun({"malformed stimulus line: ", line});
        end
        $fclose(fd);
        numVecs = vInstr.size();
    endtask

    //////////////////////////////////////////////////////////////////////
    // issue one instruction and check what comes back with ack
    //////////////////////////////////////////////////////////////////////

    task automatic runVector(input int k);
        int    waited;
        word_t expStore;
        waited   = 0;
        expStore = (vRtNum[k] == 5'd0) ? 32'd0 : vRtData[k];   // r0 reads zero
        instr    = vInstr[k];
        rsNum    = vRsNum[k];
        rtNum    = vRtNum[k];
        rsData   = vRsData[k];
        rtData   = vRtData[k];
        cyc      = 1'b1;
        stb      = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (!ack);
        if (!waitsOnMulDiv(vInstr[k]) && (waited != 1))
            stopRun($sformatf("vector %0d was acked after %0d cycles instead of 1",
                              k, waited));
        checkFlag(writeEn, vWriteEn[k], "writeEn");
        if (vWriteEn[k])
        begin
            checkReg(writeReg, vWriteReg[k], "writeReg");
            checkWord(result, vResult[k], "result");
        end
        checkWord(storeData, expStore, "storeData");
    endtask

    initial
    begin
        wait (numVecs > 0);
        #(numVecs * 40 * 40);   // 40 clocks per vector
        stopRun("no ack before timeout");
    end

    initial
    begin
        int idle;
        clk    = 1'b0;
        arstN  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        instr  = '0;
        rsNum  = '0;
        rtNum  = '0;
        rsData = '0;
        rtData = '0;
        loadStim();
        if (numVecs == 0)
            stopRun("exuStim.txt holds no vectors");
        else
        begin
            repeat (10) @(posedge clk);
            #2;
            arstN = 1'b1;
            checkFlag(ack, 1'b0, "ack after reset");
            checkFlag(writeEn, 1'b0, "writeEn after reset");
            for (int k = 0; k < numVecs; k++)
            begin
                idle = (nextRand() >> 16) % 4;   // 0 to 3 gaps between issues
                if (idle != 0)
                begin
                    cyc = 1'b0;
                    stb = 1'b0;
                    repeat (idle) @(posedge clk);
                    #2;
                end
                runVector(k);
                @(posedge clk);   // end of the ack cycle, stb still high
                #2;
                checkFlag(ack, 1'b0, "ack after the ack cycle");
            end
            cyc = 1'b0;
            stb = 1'b0;
            repeat (2) @(posedge clk);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: exuTop.sv
`timescale 1ns/1ps

module exuTop import exuTypesPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    cyc,
    input  logic    stb,
    input  instr_t  instr,
    input  regNum_t rsNum,
    input  regNum_t rtNum,
    input  word_t   rsData,
    input  word_t   rtData,
    output logic    ack,
    output word_t   result,
    output regNum_t writeReg,
    output logic    writeEn,
    output word_t   storeData
);

    word_t srcA;
    word_t rtValue;
    word_t aluResult;
    word_t hi;
    word_t lo;
    logic  busy;
    logic  start;

    exuCtrlIf ctrl ();

    assign srcA    = (rsNum == '0) ? '0 : rsData;   // r0 reads zero
    assign rtValue = (rtNum == '0) ? '0 : rtData;

    //////////////////////////////////////////////////////////////////////
    // decode, execute, result
    //////////////////////////////////////////////////////////////////////

    exuDecode uDecode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    exuAlu uAlu (
        .ctrl    (ctrl),
        .srcA    (srcA),
        .rtValue (rtValue),
        .shamt   (instr[10:6]),
        .result  (aluResult)
    );

    exuMulDiv uMulDiv (
        .clk   (clk),
        .arstN (arstN),
        .start (start),
        .op    (ctrl.mulDivOp),
        .srcA  (srcA),
        .srcB  (rtValue),
        .busy  (busy),
        .hi    (hi),
        .lo    (lo)
    );

    exuResult uResult (
        .clk       (clk),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .cyc       (cyc),
        .stb       (stb),
        .busy      (busy),
        .aluResult (aluResult),
        .hi        (hi),
        .lo        (lo),
        .start     (start),
        .ack       (ack),
        .result    (result),
        .writeReg  (writeReg),
        .writeEn   (writeEn)
    );

    // follows the pending issue, frozen through the ack cycle
    always_ff @(posedge clk)
    begin
        if (cyc && stb && !ack)
            storeData <= rtValue;
    end

endmodule

// File: exuTypesPkg.sv
package exuTypesPkg;

    //////////////////////////////////////////////////////////////////////
    // data path widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;    // register / data value
    typedef logic [31:0] instr_t;   // full instruction word
    typedef logic [4:0]  regNum_t;  // gpr index
    typedef logic [4:0]  shamt_t;   // shift amount, instr[10:6] or rs

endpackage

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the verdict
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module exuTb -f src.f -o exuSim \
    && ./obj_dir/exuSim 2>&1 | tee sim.log
[ -f sim.log ] && ! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
    && echo "simulation passed" && exit 0 \
    || echo "simulation failed"
exit 1

// File: src.f
exuTypesPkg.sv
exuIsaPkg.sv
exuCtrlIf.sv
exuDecode.sv
exuAlu.sv
exuMulDiv.sv
exuResult.sv
exuTop.sv
exuTb.sv
